// File: design/aes_io_settings.svh
// AES host bridge sizing
// byte lane width and block geometry shared by package and RTL

`ifndef AES_IO_SETTINGS_SVH
`define AES_IO_SETTINGS_SVH

// one host lane byte
`define AES_IO_BYTE_W 8

// bytes in one AES block
`define AES_IO_BLOCK_BYTES 16

// block and key width
`define AES_IO_BLOCK_W 128

// enough bits to index every byte of a block
`define AES_IO_IDX_W 4

`endif

// File: design/aes_io_pkg.sv
// AES host bridge types
// lane, index and block types plus the host command and status codes

`include "aes_io_settings.svh"

package aes_io_pkg;

  typedef logic [`AES_IO_BYTE_W-1:0] io_byte_t;

  // index 0 is the most significant byte
  typedef logic [`AES_IO_IDX_W-1:0] byte_idx_t;

  typedef logic [`AES_IO_BLOCK_W-1:0] msg_block_t;
  typedef logic [`AES_IO_BLOCK_W-1:0] aes_key_t;

  // command code from the host
  typedef enum logic [1:0] {
    HOST_IDLE = 2'd0,
    HOST_NEXT = 2'd1,
    HOST_ACK  = 2'd2,
    HOST_GO   = 2'd3
  } host_cmd_e;

  // status code to the host, idle doubles as acknowledge
  typedef enum logic [1:0] {
    STAT_IDLE   = 2'd0,
    STAT_BYTE   = 2'd1,
    STAT_RESULT = 2'd2,
    STAT_RESET  = 2'd3
  } bridge_status_e;

endpackage

// File: design/byte_collector.sv
// Byte collector
// fills a block-wide payload register one lane byte at a time, MSB first

`timescale 1ns/1ps
`include "aes_io_settings.svh"

module byte_collector
  import aes_io_pkg::*;
#(
  parameter type payload_t = msg_block_t
) (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     restart,
  input  logic     capture,
  input  io_byte_t data_byte,
  output payload_t payload,
  output logic     last
);

  localparam int LANES = $bits(payload_t) / `AES_IO_BYTE_W;

  byte_idx_t idx_q;
  payload_t  payload_q;
  int        lane_lsb;

  // index 0 lands in the top lane
  always_comb begin
    lane_lsb = (LANES - 1 - int'(idx_q)) * `AES_IO_BYTE_W;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      idx_q <= '0;
    end else if (restart) begin
      idx_q <= '0;
    end else if (capture) begin
      // wraps to zero after the final lane
      idx_q <= idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      payload_q <= '0;
    end else if (capture) begin
      payload_q[lane_lsb +: `AES_IO_BYTE_W] <= data_byte;
    end
  end

  assign payload = payload_q;

  // index back at zero once a load is under way means all lanes written
  assign last = (idx_q == '0);

  a_no_capture_on_restart : assert property (
    @(posedge clk) disable iff (!reset_n)
    !(capture && restart)
  ) else $error("byte_collector: capture and restart in the same cycle");

endmodule

// File: design/byte_emitter.sv
// Byte emitter
// walks the result block onto the outgoing lane, MSB first

`timescale 1ns/1ps
`include "aes_io_settings.svh"

module byte_emitter
  import aes_io_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       restart,
  input  logic       advance,
  input  logic       show,
  input  msg_block_t result,
  output io_byte_t   data_byte,
  output logic       last
);

  byte_idx_t idx_q;
  int        lane_lsb;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      idx_q <= '0;
    end else if (restart) begin
      idx_q <= '0;
    end else if (advance) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  always_comb begin
    lane_lsb = (`AES_IO_BLOCK_BYTES - 1 - int'(idx_q)) * `AES_IO_BYTE_W;
  end

  // lane is driven only while a byte is on offer
  always_comb begin
    if (show) begin
      data_byte = result[lane_lsb +: `AES_IO_BYTE_W];
    end else begin
      data_byte = '0;
    end
  end

  // current byte is the final one of the block
  assign last = (idx_q == byte_idx_t'(`AES_IO_BLOCK_BYTES - 1));

  a_no_advance_on_restart : assert property (
    @(posedge clk) disable iff (!reset_n)
    !(advance && restart)
  ) else $error("byte_emitter: advance and restart in the same cycle");

endmodule

// File: design/io_sequencer.sv
// Host I/O sequencer
// handshake FSM for block loads, the AES request and the result readback

`timescale 1ns/1ps

module io_sequencer
  import aes_io_pkg::*;
(
  input  logic           clk,
  input  logic           reset_n,
  input  host_cmd_e      host_cmd,
  output bridge_status_e status,
  output logic           msg_restart,
  output logic           msg_capture,
  output logic           key_restart,
  output logic           key_capture,
  output logic           emit_restart,
  output logic           emit_advance,
  output logic           emit_show,
  output logic           aes_start,
  input  logic           msg_last,
  input  logic           key_last,
  input  logic           emit_last,
  input  logic           aes_done
);

  typedef enum logic [3:0] {
    ST_RESET,
    ST_IDLE,
    ST_READ_MSG,
    ST_MSG_ACK,
    ST_READ_KEY,
    ST_KEY_ACK,
    ST_AES_WAIT,
    ST_RESULT,
    ST_SEND,
    ST_SEND_ACK
  } seq_state_e;

  seq_state_e state, next_state;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= ST_RESET;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    unique case (state)
      ST_RESET: begin
        next_state = ST_IDLE;
      end
      ST_IDLE: begin
        if (host_cmd == HOST_NEXT) begin
          next_state = ST_READ_MSG;
        end else if (host_cmd == HOST_ACK) begin
          next_state = ST_READ_KEY;
        end else if (host_cmd == HOST_GO) begin
          next_state = ST_AES_WAIT;
        end
      end
      ST_READ_MSG: begin
        if (host_cmd == HOST_ACK) begin
          next_state = ST_MSG_ACK;
        end
      end
      ST_MSG_ACK: begin
        // full message in, key load follows
        if (host_cmd == HOST_NEXT) begin
          next_state = msg_last ? ST_READ_KEY : ST_READ_MSG;
        end
      end
      ST_READ_KEY: begin
        if (host_cmd == HOST_ACK) begin
          next_state = ST_KEY_ACK;
        end
      end
      ST_KEY_ACK: begin
        // host drops to idle after the final key byte
        if (key_last) begin
          if (host_cmd == HOST_IDLE) begin
            next_state = ST_AES_WAIT;
          end
        end else if (host_cmd == HOST_NEXT) begin
          next_state = ST_READ_KEY;
        end
      end
      ST_AES_WAIT: begin
        if (aes_done) begin
          next_state = ST_RESULT;
        end
      end
      ST_RESULT: begin
        if (host_cmd == HOST_NEXT) begin
          next_state = ST_SEND;
        end
      end
      ST_SEND: begin
        if (host_cmd == HOST_ACK) begin
          next_state = ST_SEND_ACK;
        end
      end
      ST_SEND_ACK: begin
        if (host_cmd == HOST_NEXT) begin
          next_state = emit_last ? ST_IDLE : ST_SEND;
        end
      end
      default: begin
        next_state = ST_RESET;
      end
    endcase
  end

  // status is a pure function of the state
  always_comb begin
    unique case (state)
      ST_RESET:                          status = STAT_RESET;
      ST_READ_MSG, ST_READ_KEY, ST_SEND: status = STAT_BYTE;
      ST_RESULT:                         status = STAT_RESULT;
      default:                           status = STAT_IDLE;
    endcase
  end

  // request held through result announcement
  assign aes_start = (state == ST_AES_WAIT) || (state == ST_RESULT);

  // index restarts as the FSM leaves idle
  assign msg_restart  = (state == ST_IDLE) && (host_cmd == HOST_NEXT);
  assign key_restart  = (state == ST_IDLE) && (host_cmd != HOST_IDLE) && (host_cmd != HOST_GO);
  assign emit_restart = (state == ST_IDLE) && (host_cmd != HOST_IDLE);

  assign msg_capture  = (state == ST_READ_MSG) && (host_cmd == HOST_ACK);
  assign key_capture  = (state == ST_READ_KEY) && (host_cmd == HOST_ACK);
  assign emit_advance = (state == ST_SEND_ACK) && (host_cmd == HOST_NEXT);
  assign emit_show    = (state == ST_SEND);

  // a capture happens in a read phase and hands over to its ack phase
  a_capture_in_read : assert property (
    @(posedge clk) disable iff (!reset_n)
    (msg_capture || key_capture) |=> ($past(status) == STAT_BYTE && status == STAT_IDLE)
  ) else $error("io_sequencer: capture outside a read phase");

  // request may not drop before the core has answered
  a_start_held : assert property (
    @(posedge clk) disable iff (!reset_n)
    (aes_start && !aes_done && status != STAT_RESULT) |=> aes_start
  ) else $error("io_sequencer: aes_start dropped before aes_done");

endmodule

// File: design/aes_io_bridge.sv
// AES host I/O bridge
// loads message and key from the host lane, requests the cipher, returns the result

`timescale 1ns/1ps

module aes_io_bridge
  import aes_io_pkg::*;
(
  input  logic           clk,
  input  logic           reset_n,
  input  host_cmd_e      host_cmd,
  input  io_byte_t       host_data,
  output bridge_status_e status,
  output io_byte_t       result_byte,
  output msg_block_t     msg_block,
  output aes_key_t       key,
  output logic           aes_start,
  input  logic           aes_done,
  input  msg_block_t     aes_result
);

  logic msg_restart, msg_capture, msg_last;
  logic key_restart, key_capture, key_last;
  logic emit_restart, emit_advance, emit_show, emit_last;

  io_sequencer u_sequencer (
    .clk          (clk),
    .reset_n      (reset_n),
    .host_cmd     (host_cmd),
    .status       (status),
    .msg_restart  (msg_restart),
    .msg_capture  (msg_capture),
    .key_restart  (key_restart),
    .key_capture  (key_capture),
    .emit_restart (emit_restart),
    .emit_advance (emit_advance),
    .emit_show    (emit_show),
    .aes_start    (aes_start),
    .msg_last     (msg_last),
    .key_last     (key_last),
    .emit_last    (emit_last),
    .aes_done     (aes_done)
  );

  byte_collector #(.payload_t(msg_block_t)) u_msg_collector (
    .clk       (clk),
    .reset_n   (reset_n),
    .restart   (msg_restart),
    .capture   (msg_capture),
    .data_byte (host_data),
    .payload   (msg_block),
    .last      (msg_last)
  );

  byte_collector #(.payload_t(aes_key_t)) u_key_collector (
    .clk       (clk),
    .reset_n   (reset_n),
    .restart   (key_restart),
    .capture   (key_capture),
    .data_byte (host_data),
    .payload   (key),
    .last      (key_last)
  );

  byte_emitter u_emitter (
    .clk       (clk),
    .reset_n   (reset_n),
    .restart   (emit_restart),
    .advance   (emit_advance),
    .show      (emit_show),
    .result    (aes_result),
    .data_byte (result_byte),
    .last      (emit_last)
  );

endmodule

// File: bench/aes_io_bridge_tb.sv
// AES host bridge testbench
// host and AES core models run a table of loads, go requests and readbacks

`timescale 1ns/1ps
`include "aes_io_settings.svh"

module aes_io_bridge_tb
  import aes_io_pkg::*;
();

  localparam int NUM_ROWS     = 6;
  localparam int RESET_CYCLES = 4;
  localparam int NBYTES       = `AES_IO_BLOCK_BYTES;
  localparam int BW           = `AES_IO_BYTE_W;

  typedef enum int {MODE_FULL, MODE_KEY_ONLY, MODE_GO} row_mode_e;

  logic           clk = 1'b0;
  logic           reset_n;
  host_cmd_e      host_cmd;
  io_byte_t       host_data;
  bridge_status_e status;
  io_byte_t       result_byte;
  msg_block_t     msg_block;
  aes_key_t       key;
  logic           aes_start;
  logic           aes_done;
  msg_block_t     aes_result;

  // transaction table, stimulus plus expected block contents
  string      row_name [NUM_ROWS] = '{"full_a", "key_only_a", "go_a",
                                      "full_b", "go_b", "key_only_b"};
  row_mode_e  row_mode [NUM_ROWS] = '{MODE_FULL, MODE_KEY_ONLY, MODE_GO,
                                      MODE_FULL, MODE_GO, MODE_KEY_ONLY};
  msg_block_t row_msg [NUM_ROWS];
  aes_key_t   row_key [NUM_ROWS];
  int         row_delay [NUM_ROWS];
  msg_block_t row_exp_msg [NUM_ROWS];
  aes_key_t   row_exp_key [NUM_ROWS];
  msg_block_t row_exp_result [NUM_ROWS];

  integer seed = 38132;
  string  active_name = "reset";
  int     active_delay = 1;
  int     check_count = 0;
  int     error_count = 0;
  int     watchdog_cycles = 0;

  aes_io_bridge u_aes_io_bridge (
    .clk         (clk),
    .reset_n     (reset_n),
    .host_cmd    (host_cmd),
    .host_data   (host_data),
    .status      (status),
    .result_byte (result_byte),
    .msg_block   (msg_block),
    .key         (key),
    .aes_start   (aes_start),
    .aes_done    (aes_done),
    .aes_result  (aes_result)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string what, input logic [127:0] expected,
                             input logic [127:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch in %s: %s expected %h actual %h", active_name, what, expected, actual);
    end
  endtask

  function automatic logic [127:0] random_block();
    random_block = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // message and key the bridge should hold after each row
  task automatic fill_table();
    msg_block_t held_msg;
    aes_key_t   held_key;
    held_msg = '0;
    held_key = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_msg[r]   = random_block();
      row_key[r]   = random_block();
      row_delay[r] = 1 + int'($unsigned($random(seed)) % 12);
      if (row_mode[r] == MODE_FULL) begin
        held_msg = row_msg[r];
        held_key = row_key[r];
      end else if (row_mode[r] == MODE_KEY_ONLY) begin
        held_key = row_key[r];
      end
      row_exp_msg[r]    = held_msg;
      row_exp_key[r]    = held_key;
      row_exp_result[r] = held_msg ^ held_key;
    end
  endtask

  // sampled on the falling edge, so the state is settled
  task automatic wait_status(input bridge_status_e want);
    do begin
      @(negedge clk);
    end while (status != want);
  endtask

  task automatic load_block(input logic [127:0] block, input bit is_key);
    for (int i = 0; i < NBYTES; i++) begin
      wait_status(STAT_BYTE);
      check_value("aes_start during load", 128'd0, 128'(aes_start));
      host_data = block[(NBYTES - 1 - i) * BW +: BW];
      host_cmd  = HOST_ACK;
      wait_status(STAT_IDLE);
      check_value("aes_start in load ack", 128'd0, 128'(aes_start));
      // final key byte is closed with idle
      if (is_key && i == NBYTES - 1) begin
        host_cmd = HOST_IDLE;
      end else begin
        host_cmd = HOST_NEXT;
      end
    end
  endtask

  task automatic run_request(input row_mode_e mode, input msg_block_t msg, input aes_key_t k);
    @(negedge clk);
    if (mode == MODE_FULL) begin
      host_cmd = HOST_NEXT;
      load_block(msg, 1'b0);
      load_block(k, 1'b1);
      @(negedge clk);
    end else if (mode == MODE_KEY_ONLY) begin
      host_cmd = HOST_ACK;
      load_block(k, 1'b1);
      @(negedge clk);
    end else begin
      host_cmd = HOST_GO;
      @(negedge clk);
      host_cmd = HOST_IDLE;
    end
    check_value("aes_start after request", 128'd1, 128'(aes_start));
  endtask

  task automatic read_result(input msg_block_t expected);
    wait_status(STAT_RESULT);
    check_value("aes_start during result", 128'd1, 128'(aes_start));
    host_cmd = HOST_NEXT;
    for (int i = 0; i < NBYTES; i++) begin
      wait_status(STAT_BYTE);
      check_value("result byte", 128'(expected[(NBYTES - 1 - i) * BW +: BW]),
                  128'(result_byte));
      host_cmd = HOST_ACK;
      wait_status(STAT_IDLE);
      check_value("result byte in send ack", 128'd0, 128'(result_byte));
      host_cmd = HOST_NEXT;
    end
    @(negedge clk);
    host_cmd = HOST_IDLE;
    check_value("status after readback", 128'(STAT_IDLE), 128'(status));
    check_value("aes_start after readback", 128'd0, 128'(aes_start));
    @(negedge clk);
    check_value("status stays idle", 128'(STAT_IDLE), 128'(status));
  endtask

  // AES core stand-in, result is message xor key
  initial begin : aes_model
    aes_done   = 1'b0;
    aes_result = '0;
    forever begin
      do begin
        @(negedge clk);
      end while (aes_start !== 1'b1);
      for (int d = 0; d < active_delay; d++) begin
        @(negedge clk);
        check_value("aes_start held before done", 128'd1, 128'(aes_start));
      end
      aes_result = msg_block ^ key;
      aes_done   = 1'b1;
      @(negedge clk);
      aes_done = 1'b0;
      do begin
        @(negedge clk);
      end while (aes_start === 1'b1);
    end
  end

  initial begin : watchdog
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Run timed out after %0d cycles, bridge stopped responding in %s",
             watchdog_cycles, active_name);
    $display("Something failed");
    $finish;
  end

  initial begin : main_sequence
    int errors_before;
    int max_delay;
    reset_n   = 1'b0;
    host_cmd  = HOST_IDLE;
    host_data = '0;
    fill_table();
    max_delay = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (row_delay[r] > max_delay) begin
        max_delay = row_delay[r];
      end
    end
    watchdog_cycles = NUM_ROWS * (2 * NBYTES * 4 + NBYTES * 4 + max_delay + 20) + RESET_CYCLES;

    repeat (RESET_CYCLES) @(negedge clk);
    check_value("status in reset", 128'(STAT_RESET), 128'(status));
    check_value("aes_start in reset", 128'd0, 128'(aes_start));
    check_value("msg_block in reset", 128'd0, msg_block);
    check_value("key in reset", 128'd0, key);
    reset_n = 1'b1;
    @(negedge clk);
    check_value("status after reset", 128'(STAT_IDLE), 128'(status));
    $display("row - reset      %s", (error_count == 0) ? "passed" : "FAILED");

    for (int r = 0; r < NUM_ROWS; r++) begin
      active_name   = row_name[r];
      active_delay  = row_delay[r];
      errors_before = error_count;
      run_request(row_mode[r], row_msg[r], row_key[r]);
      check_value("msg_block", row_exp_msg[r], msg_block);
      check_value("key", row_exp_key[r], key);
      read_result(row_exp_result[r]);
      $display("row %0d %-10s %-13s delay %0d %s", r, row_name[r], row_mode[r].name(),
               row_delay[r], (error_count == errors_before) ? "passed" : "FAILED");
    end

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+design
design/aes_io_pkg.sv
design/byte_collector.sv
design/byte_emitter.sv
design/io_sequencer.sv
design/aes_io_bridge.sv
bench/aes_io_bridge_tb.sv

// File: run.sh
#!/bin/sh
# compile the bridge testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module aes_io_bridge_tb -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/Vaes_io_bridge_tb)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Everything OK"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
